// File: hdl/spi_bridge_settings.svh
`ifndef SPI_BRIDGE_SETTINGS_SVH
`define SPI_BRIDGE_SETTINGS_SVH

// bus widths
`define SPI_DATA_W 16
`define SPI_ADDR_W 12

// register map, word addresses
`define REG_PAD0       12'h004
`define REG_PAD1       12'h005
`define REG_PAD2       12'h006
`define REG_PAD_STICKS 12'h007  // decoded, read only
`define REG_PAD_RIGHT  12'h008
`define REG_PAD_TRIG   12'h009
`define REG_DPIN       12'h00F
`define REG_CPIN       12'h010
`define REG_MUX        12'h011
`define REG_SYSCTL     12'h014
`define REG_SPI_DATA   12'h020
`define REG_SPI_STAT   12'h021  // bit 0 is idle

// bit positions inside a pin group
`define PIN_CS   5
`define PIN_SCK  4
`define PIN_IO3  3
`define PIN_IO2  2
`define PIN_MISO 1
`define PIN_MOSI 0

`define PIN_RESET_VAL (6'd1 << `PIN_CS)  // cs idles high

`define SPI_BITS 16  // two clk50 cycles per bit

`endif

// File: hdl/spi_bridge_pkg.sv
package spi_bridge_pkg;

  // 5 .. 0 : cs sck io3 io2 miso mosi
  typedef struct packed {
    logic cs;
    logic sck;
    logic io3;
    logic io2;
    logic miso;
    logic mosi;
  } pin_group_t;

  typedef struct packed {
    logic host_d;  // host drives group d
    logic host_c;  // host drives group c
  } mux_sel_t;

  typedef logic [47:0] pad_report_t;

  typedef logic [4:0] spi_cnt_t;  // half-period counter of the engine

  typedef struct packed {
    logic [5:0] lx;
    logic [5:0] ly;
    logic [4:0] rx;
    logic [4:0] ry;
    logic [4:0] lt;
    logic [4:0] rt;
  } pad_fields_t;

  // only the first 32 bits of the report carry stick data
  function automatic pad_fields_t pad_decode(input pad_report_t r);
    pad_fields_t f;
    f.lx = r[5:0];
    f.ly = r[13:8];
    f.rx = {r[7:6], r[15:14], r[23]};  // rx is scattered over three bytes
    f.ry = r[20:16];
    f.lt = {r[22:21], r[31:29]};
    f.rt = r[28:24];
    return f;
  endfunction

endpackage

// File: hdl/io_regs.sv
`timescale 1ns/1ps
`include "spi_bridge_settings.svh"

module io_regs
  import spi_bridge_pkg::*;
(
  input  logic                   clk50,
  input  logic                   SCKclock,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`SPI_ADDR_W-1:0] paddr_i,
  input  logic [`SPI_DATA_W-1:0] pwdata_i,
  output logic [`SPI_DATA_W-1:0] prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  input  logic                   spi_idle_i,
  input  logic [`SPI_DATA_W-1:0] spi_rx_i,
  output logic                   spi_start_o,
  output logic [`SPI_DATA_W-1:0] spi_tx_o,
  output pin_group_t             d_pins_o,
  output pin_group_t             c_pins_o,
  output mux_sel_t               mux_sel_o,
  output logic                   sys_en_o,
  input  logic                   d_miso_i,
  input  logic                   c_miso_i
);

  logic                   access;
  logic                   addr_hit;
  logic                   wr_en;
  logic                   start_q;
  logic [`SPI_DATA_W-1:0] spi_tx_q;
  logic [`SPI_DATA_W-1:0] sysctl_q;
  pin_group_t             d_pins_q;
  pin_group_t             c_pins_q;
  mux_sel_t               mux_q;
  pad_report_t            pad_q;
  pad_fields_t            pad_f;

  // pin register as read back, miso bit taken live from the pin
  function automatic logic [`SPI_DATA_W-1:0] pin_rd(input pin_group_t p, input logic miso);
    logic [`SPI_DATA_W-1:0] w;
    w = `SPI_DATA_W'(p);
    w[`PIN_MISO] = miso;
    return w;
  endfunction

  ////////////////////
  // apb decode

  assign access = psel_i & penable_i;

  // only a data write during a transfer waits
  assign pready_o = ~(access & pwrite_i & (paddr_i == `REG_SPI_DATA) & ~spi_idle_i);

  always_comb begin
    case (paddr_i)
      `REG_PAD0, `REG_PAD1, `REG_PAD2,
      `REG_PAD_STICKS, `REG_PAD_RIGHT, `REG_PAD_TRIG,
      `REG_DPIN, `REG_CPIN, `REG_MUX, `REG_SYSCTL,
      `REG_SPI_DATA, `REG_SPI_STAT: addr_hit = 1'b1;
      default:                      addr_hit = 1'b0;
    endcase
  end

  assign pslverr_o = access & ~addr_hit;
  assign wr_en     = access & pwrite_i & pready_o & addr_hit;

  ////////////////////
  // registers

  always_ff @(posedge clk50 or posedge SCKclock) begin
    if (SCKclock) begin
      d_pins_q <= `PIN_RESET_VAL;
      c_pins_q <= `PIN_RESET_VAL;
      mux_q    <= '0;
      sysctl_q <= '0;
      pad_q    <= '0;
      spi_tx_q <= '0;
      start_q  <= 1'b0;
    end else begin
      start_q <= 1'b0;  // one-cycle pulse
      if (wr_en) begin
        case (paddr_i)
          `REG_DPIN:   d_pins_q <= pin_group_t'(pwdata_i[5:0]);
          `REG_CPIN:   c_pins_q <= pin_group_t'(pwdata_i[5:0]);
          `REG_MUX:    mux_q    <= mux_sel_t'(pwdata_i[1:0]);
          `REG_SYSCTL: sysctl_q <= pwdata_i;
          `REG_PAD0:   pad_q[`SPI_DATA_W-1:0] <= pwdata_i;
          `REG_PAD1:   pad_q[2*`SPI_DATA_W-1:`SPI_DATA_W] <= pwdata_i;
          `REG_PAD2:   pad_q[3*`SPI_DATA_W-1:2*`SPI_DATA_W] <= pwdata_i;
          `REG_SPI_DATA: begin
            spi_tx_q <= pwdata_i;
            start_q  <= 1'b1;
          end
          default: ;  // read-only words
        endcase
      end
    end
  end

  assign pad_f = pad_decode(pad_q);

  ////////////////////
  // read data

  always_comb begin
    case (paddr_i)
      `REG_PAD0:       prdata_o = pad_q[`SPI_DATA_W-1:0];
      `REG_PAD1:       prdata_o = pad_q[2*`SPI_DATA_W-1:`SPI_DATA_W];
      `REG_PAD2:       prdata_o = pad_q[3*`SPI_DATA_W-1:2*`SPI_DATA_W];
      `REG_PAD_STICKS: prdata_o = {2'b00, pad_f.ly, 2'b00, pad_f.lx};
      `REG_PAD_RIGHT:  prdata_o = {3'b000, pad_f.ry, 3'b000, pad_f.rx};
      `REG_PAD_TRIG:   prdata_o = {3'b000, pad_f.rt, 3'b000, pad_f.lt};
      `REG_DPIN:       prdata_o = pin_rd(d_pins_q, d_miso_i);
      `REG_CPIN:       prdata_o = pin_rd(c_pins_q, c_miso_i);
      `REG_MUX:        prdata_o = {{(`SPI_DATA_W-2){1'b0}}, mux_q};
      `REG_SYSCTL:     prdata_o = sysctl_q;
      `REG_SPI_DATA:   prdata_o = spi_rx_i;
      `REG_SPI_STAT:   prdata_o = {{(`SPI_DATA_W-1){1'b0}}, spi_idle_i};
      default:         prdata_o = '0;
    endcase
  end

  assign spi_start_o = start_q;
  assign spi_tx_o    = spi_tx_q;
  assign d_pins_o    = d_pins_q;
  assign c_pins_o    = c_pins_q;
  assign mux_sel_o   = mux_q;
  assign sys_en_o    = sysctl_q[0];  // panel power enable

endmodule

// File: hdl/spi_engine.sv
`timescale 1ns/1ps
`include "spi_bridge_settings.svh"

module spi_engine
  import spi_bridge_pkg::*;
(
  input  logic                   clk50,
  input  logic                   SCKclock,
  input  logic                   start_i,
  input  logic [`SPI_DATA_W-1:0] tx_i,
  input  logic                   miso_i,
  output logic [`SPI_DATA_W-1:0] rx_o,
  output logic                   idle_o,
  output logic                   sck_o,
  output logic                   mosi_o
);

  // two half periods per bit
  localparam spi_cnt_t last_count = spi_cnt_t'(2 * `SPI_BITS - 1);

  logic                   running;
  spi_cnt_t               count;
  logic [`SPI_DATA_W-1:0] shifter;

  always_ff @(posedge clk50 or posedge SCKclock) begin
    if (SCKclock) begin
      running <= 1'b0;
      count   <= '0;
      shifter <= '0;  // mosi feeds the pins, keep it defined
    end else if (start_i) begin
      running <= 1'b1;
      count   <= '0;
      shifter <= tx_i;
    end else if (running) begin
      if (count == last_count) begin
        running <= 1'b0;
        count   <= '0;
      end else begin
        count <= count + 1'b1;
      end
      // sample on sck high, mosi moves with the shift
      if (count[0])
        shifter <= {shifter[`SPI_DATA_W-2:0], miso_i};
    end
  end

  assign rx_o   = shifter;
  assign idle_o = ~running;
  assign sck_o  = count[0];  // mode 0, low when idle
  assign mosi_o = shifter[`SPI_DATA_W-1];

endmodule

// File: hdl/pin_mux.sv
`timescale 1ns/1ps
`include "spi_bridge_settings.svh"

module pin_mux
  import spi_bridge_pkg::*;
(
  input  pin_group_t d_pins_i,
  input  pin_group_t c_pins_i,
  input  logic       eng_sck_i,
  input  logic       eng_mosi_i,
  input  mux_sel_t   mux_sel_i,
  input  logic       h_cs_i,
  input  logic       h_sck_i,
  input  logic       h_mosi_i,
  input  logic       c_miso_i,
  input  logic       d_miso_i,
  output logic       d_cs_o,
  output logic       d_sck_o,
  output logic       d_io3_o,
  output logic       d_io2_o,
  output logic       d_mosi_o,
  output logic       c_cs_o,
  output logic       c_sck_o,
  output logic       c_io3_o,
  output logic       c_io2_o,
  output logic       c_mosi_o,
  output logic       h_miso_o
);

  pin_group_t host_grp;
  pin_group_t c_eng_grp;
  pin_group_t d_out;
  pin_group_t c_out;

  always_comb begin
    host_grp            = '0;  // io2, io3 stay low
    host_grp[`PIN_CS]   = h_cs_i;
    host_grp[`PIN_SCK]  = h_sck_i;
    host_grp[`PIN_MOSI] = h_mosi_i;

    // engine is ORed onto the c register
    c_eng_grp            = c_pins_i;
    c_eng_grp[`PIN_SCK]  = c_pins_i[`PIN_SCK] | eng_sck_i;
    c_eng_grp[`PIN_MOSI] = c_pins_i[`PIN_MOSI] | eng_mosi_i;
  end

  assign d_out = mux_sel_i.host_d ? host_grp : d_pins_i;
  assign c_out = mux_sel_i.host_c ? host_grp : c_eng_grp;

  assign d_cs_o   = d_out[`PIN_CS];
  assign d_sck_o  = d_out[`PIN_SCK];
  assign d_io3_o  = d_out[`PIN_IO3];
  assign d_io2_o  = d_out[`PIN_IO2];
  assign d_mosi_o = d_out[`PIN_MOSI];
  assign c_cs_o   = c_out[`PIN_CS];
  assign c_sck_o  = c_out[`PIN_SCK];
  assign c_io3_o  = c_out[`PIN_IO3];
  assign c_io2_o  = c_out[`PIN_IO2];
  assign c_mosi_o = c_out[`PIN_MOSI];

  always_comb begin
    if (h_cs_i) begin
      h_miso_o = 1'b0;  // host not selecting
    end else begin
      case (mux_sel_i)
        2'b01:   h_miso_o = c_miso_i;
        2'b10:   h_miso_o = d_miso_i;
        default: h_miso_o = 1'b0;
      endcase
    end
  end

endmodule

// File: hdl/spi_bridge_top.sv
`timescale 1ns/1ps
`include "spi_bridge_settings.svh"

module spi_bridge_top
  import spi_bridge_pkg::*;
(
  input  logic                   clk50,
  input  logic                   SCKclock,
  // apb slave
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`SPI_ADDR_W-1:0] paddr_i,
  input  logic [`SPI_DATA_W-1:0] pwdata_i,
  output logic [`SPI_DATA_W-1:0] prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  // group d, flash side
  output logic                   d_cs_o,
  output logic                   d_sck_o,
  output logic                   d_io3_o,
  output logic                   d_io2_o,
  output logic                   d_mosi_o,
  input  logic                   d_miso_i,
  // group c, engine side
  output logic                   c_cs_o,
  output logic                   c_sck_o,
  output logic                   c_io3_o,
  output logic                   c_io2_o,
  output logic                   c_mosi_o,
  input  logic                   c_miso_i,
  // host pass-through
  input  logic                   h_cs_i,
  input  logic                   h_sck_i,
  input  logic                   h_mosi_i,
  output logic                   h_miso_o,
  output logic                   sys_en_o
);

  logic                   spi_start;
  logic                   spi_idle;
  logic                   eng_sck;
  logic                   eng_mosi;
  logic [`SPI_DATA_W-1:0] spi_tx;
  logic [`SPI_DATA_W-1:0] spi_rx;
  pin_group_t             d_pins;
  pin_group_t             c_pins;
  mux_sel_t               mux_sel;

  io_regs io_regs_inst (
    .clk50       (clk50),
    .SCKclock    (SCKclock),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .spi_idle_i  (spi_idle),
    .spi_rx_i    (spi_rx),
    .spi_start_o (spi_start),
    .spi_tx_o    (spi_tx),
    .d_pins_o    (d_pins),
    .c_pins_o    (c_pins),
    .mux_sel_o   (mux_sel),
    .sys_en_o    (sys_en_o),
    .d_miso_i    (d_miso_i),
    .c_miso_i    (c_miso_i)
  );

  spi_engine spi_engine_inst (
    .clk50    (clk50),
    .SCKclock (SCKclock),
    .start_i  (spi_start),
    .tx_i     (spi_tx),
    .miso_i   (c_miso_i),  // engine listens on group c
    .rx_o     (spi_rx),
    .idle_o   (spi_idle),
    .sck_o    (eng_sck),
    .mosi_o   (eng_mosi)
  );

  pin_mux pin_mux_inst (
    .d_pins_i   (d_pins),
    .c_pins_i   (c_pins),
    .eng_sck_i  (eng_sck),
    .eng_mosi_i (eng_mosi),
    .mux_sel_i  (mux_sel),
    .h_cs_i     (h_cs_i),
    .h_sck_i    (h_sck_i),
    .h_mosi_i   (h_mosi_i),
    .c_miso_i   (c_miso_i),
    .d_miso_i   (d_miso_i),
    .d_cs_o     (d_cs_o),
    .d_sck_o    (d_sck_o),
    .d_io3_o    (d_io3_o),
    .d_io2_o    (d_io2_o),
    .d_mosi_o   (d_mosi_o),
    .c_cs_o     (c_cs_o),
    .c_sck_o    (c_sck_o),
    .c_io3_o    (c_io3_o),
    .c_io2_o    (c_io2_o),
    .c_mosi_o   (c_mosi_o),
    .h_miso_o   (h_miso_o)
  );

endmodule

// File: tb/spi_bridge_properties.sv
`timescale 1ns/1ps
`include "spi_bridge_settings.svh"

module spi_bridge_properties (
  input logic                   clk50,
  input logic                   SCKclock,
  input logic                   psel_i,
  input logic                   penable_i,
  input logic                   pwrite_i,
  input logic [`SPI_ADDR_W-1:0] paddr_i,
  input logic                   pready_o,
  input logic                   pslverr_o,
  input logic [5:0]             d_pins,
  input logic [5:0]             c_pins,
  input logic [1:0]             mux_sel,
  input logic                   eng_sck,
  input logic                   eng_mosi,
  input logic                   h_cs_i,
  input logic                   h_sck_i,
  input logic                   h_mosi_i,
  input logic [4:0]             d_out,
  input logic [4:0]             c_out
);

  function automatic logic mapped(input logic [`SPI_ADDR_W-1:0] a);
    return a inside {`REG_PAD0, `REG_PAD1, `REG_PAD2, `REG_PAD_STICKS, `REG_PAD_RIGHT,
                     `REG_PAD_TRIG, `REG_DPIN, `REG_CPIN, `REG_MUX, `REG_SYSCTL,
                     `REG_SPI_DATA, `REG_SPI_STAT};
  endfunction

  logic [4:0] host_grp;
  assign host_grp = {h_cs_i, h_sck_i, 2'b00, h_mosi_i};

  slverr_map: assert property (@(posedge clk50) disable iff (SCKclock)
    pslverr_o == (psel_i && penable_i && !mapped(paddr_i)))
    else $error("pslverr_o does not match the register map");

  wait_only_spi_write: assert property (@(posedge clk50) disable iff (SCKclock)
    !pready_o |-> (psel_i && penable_i && pwrite_i && paddr_i == `REG_SPI_DATA))
    else $error("pready_o low outside a SPI data write");

  cs_after_reset: assert property (@(posedge clk50) $fell(SCKclock) |-> d_out[4] && c_out[4])
    else $error("chip selects not high after reset");

  d_routing: assert property (@(posedge clk50) disable iff (SCKclock)
    d_out == (mux_sel[1] ? host_grp : {d_pins[5:2], d_pins[0]}))
    else $error("group d outputs break the routing rule");

  c_routing: assert property (@(posedge clk50) disable iff (SCKclock)
    c_out == (mux_sel[0] ? host_grp :
              {c_pins[5], c_pins[4] | eng_sck, c_pins[3:2], c_pins[0] | eng_mosi}))
    else $error("group c outputs break the routing rule");

endmodule

bind spi_bridge_top spi_bridge_properties spi_bridge_properties_inst (
  .clk50     (clk50),
  .SCKclock  (SCKclock),
  .psel_i    (psel_i),
  .penable_i (penable_i),
  .pwrite_i  (pwrite_i),
  .paddr_i   (paddr_i),
  .pready_o  (pready_o),
  .pslverr_o (pslverr_o),
  .d_pins    (d_pins),
  .c_pins    (c_pins),
  .mux_sel   (mux_sel),
  .eng_sck   (eng_sck),
  .eng_mosi  (eng_mosi),
  .h_cs_i    (h_cs_i),
  .h_sck_i   (h_sck_i),
  .h_mosi_i  (h_mosi_i),
  .d_out     ({d_cs_o, d_sck_o, d_io3_o, d_io2_o, d_mosi_o}),
  .c_out     ({c_cs_o, c_sck_o, c_io3_o, c_io2_o, c_mosi_o})
);

// File: tb/spi_bridge_tb.sv
`timescale 1ns/1ps
`include "spi_bridge_settings.svh"

module spi_bridge_tb;

  localparam int max_cycles = 2000;

  logic                   clk50;
  logic                   SCKclock;
  logic                   psel_i;
  logic                   penable_i;
  logic                   pwrite_i;
  logic [`SPI_ADDR_W-1:0] paddr_i;
  logic [`SPI_DATA_W-1:0] pwdata_i;
  logic [`SPI_DATA_W-1:0] prdata_o;
  logic                   pready_o;
  logic                   pslverr_o;
  logic                   d_cs_o;
  logic                   d_sck_o;
  logic                   d_io3_o;
  logic                   d_io2_o;
  logic                   d_mosi_o;
  logic                   d_miso_i;
  logic                   c_cs_o;
  logic                   c_sck_o;
  logic                   c_io3_o;
  logic                   c_io2_o;
  logic                   c_mosi_o;
  logic                   c_miso_i;
  logic                   h_cs_i;
  logic                   h_sck_i;
  logic                   h_mosi_i;
  logic                   h_miso_o;
  logic                   sys_en_o;

  integer                 seed;
  logic                   run_ended;
  logic                   err;
  int                     waits;
  logic [`SPI_DATA_W-1:0] rd;
  logic [`SPI_DATA_W-1:0] w0;
  logic [`SPI_DATA_W-1:0] w1;
  logic [`SPI_DATA_W-1:0] w2;
  logic [`SPI_DATA_W-1:0] exp_v;

  assign c_miso_i = c_mosi_o;  // loopback on group c

  spi_bridge_top spi_bridge_top_inst (.*);

  always #5 clk50 = ~clk50;

  ////////////////////
  // helpers

  task automatic check_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp) else begin
      $display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
      $display("Testbench failed");
      run_ended = 1'b1;
      $fatal(1);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("check failed at %0t ns: %s", $time, what);
      $display("Testbench failed");
      run_ended = 1'b1;
      $fatal(1);
    end
  endtask

  // setup on one falling edge, access on the next, held until pready
  task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [15:0] data,
                            output logic [15:0] rdata, output logic slverr, output int stall);
    stall     = 0;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = data;
    @(negedge clk50);
    penable_i = 1'b1;
    @(posedge clk50);
    while (!pready_o) begin
      stall++;
      @(posedge clk50);
    end
    rdata  = prdata_o;
    slverr = pslverr_o;
    @(negedge clk50);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [15:0] data);
    logic [15:0] unused_rd;
    apb_access(1'b1, addr, data, unused_rd, err, waits);
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [15:0] data);
    apb_access(1'b0, addr, 16'h0000, data, err, waits);
  endtask

  task automatic wait_spi_idle();
    logic [15:0] stat;
    int polls;
    polls = 0;
    stat  = 16'h0000;
    while (stat[0] !== 1'b1 && polls < 100) begin
      apb_read(`REG_SPI_STAT, stat);
      polls++;
    end
    check_true(stat[0] === 1'b1, "SPI engine never returned to idle");
  endtask

  ////////////////////
  // stimulus

  initial begin
    seed      = 32'h0b16_d57d;
    run_ended = 1'b0;
    clk50     = 1'b0;
    SCKclock  = 1'b1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    d_miso_i  = 1'b1;
    h_cs_i    = 1'b1;
    h_sck_i   = 1'b0;
    h_mosi_i  = 1'b0;
    repeat (10) @(negedge clk50);
    SCKclock = 1'b0;
    @(negedge clk50);

    // pin, mux and system registers
    w0 = $random(seed);
    apb_write(`REG_DPIN, w0);
    apb_read(`REG_DPIN, rd);
    check_eq("prdata_o DPIN", rd, {10'd0, w0[5:2], d_miso_i, w0[0]});
    w0 = $random(seed);
    apb_write(`REG_CPIN, w0);
    apb_read(`REG_CPIN, rd);
    check_eq("prdata_o CPIN", rd, {10'd0, w0[5:2], w0[0], w0[0]});  // miso = own mosi
    w0 = $random(seed);
    apb_write(`REG_SYSCTL, w0);
    apb_read(`REG_SYSCTL, rd);
    check_eq("prdata_o SYSCTL", rd, w0);
    check_eq("sys_en_o", {15'd0, sys_en_o}, {15'd0, w0[0]});
    w0 = $random(seed);
    apb_write(`REG_MUX, w0);
    apb_read(`REG_MUX, rd);
    check_eq("prdata_o MUX", rd, {14'd0, w0[1:0]});

    // spi loopback with the c group quiet
    apb_write(`REG_MUX, 16'h0000);
    apb_write(`REG_CPIN, 16'h0020);
    w1 = $random(seed);
    apb_write(`REG_SPI_DATA, w1);
    apb_read(`REG_SPI_STAT, rd);
    check_eq("prdata_o SPI_STAT busy", rd, 16'h0000);
    wait_spi_idle();
    apb_read(`REG_SPI_DATA, rd);
    check_eq("prdata_o SPI_DATA", rd, w1);

    // second write while busy stalls
    w1 = $random(seed);
    w2 = $random(seed);
    apb_write(`REG_SPI_DATA, w1);
    apb_write(`REG_SPI_DATA, w2);
    check_true(waits > 0, "write to busy SPI data register was not stalled");
    wait_spi_idle();
    apb_read(`REG_SPI_DATA, rd);
    check_eq("prdata_o SPI_DATA stalled", rd, w2);

    // host routing
    apb_write(`REG_MUX, 16'h0002);
    h_cs_i   = 1'b0;
    h_sck_i  = 1'b1;
    h_mosi_i = 1'b1;
    @(posedge clk50);
    check_eq("d pins", {d_cs_o, d_sck_o, d_io3_o, d_io2_o, d_mosi_o}, 16'h0009);
    check_eq("h_miso_o mux 10", h_miso_o, d_miso_i);
    @(negedge clk50);
    apb_write(`REG_MUX, 16'h0001);
    h_sck_i  = 1'b0;
    @(posedge clk50);
    check_eq("c pins", {c_cs_o, c_sck_o, c_io3_o, c_io2_o, c_mosi_o}, 16'b00000001);
    check_eq("h_miso_o mux 01", h_miso_o, 1'b1);  // host mosi looped back
    @(negedge clk50);
    h_cs_i = 1'b1;
    @(posedge clk50);
    check_eq("h_miso_o cs high", h_miso_o, 1'b0);
    @(negedge clk50);
    apb_write(`REG_MUX, 16'h0000);
    apb_write(`REG_DPIN, 16'h002d);
    apb_write(`REG_CPIN, 16'h001c);
    @(posedge clk50);
    check_eq("d pins from register", {d_cs_o, d_sck_o, d_io3_o, d_io2_o, d_mosi_o}, 16'h0017);
    check_eq("c pins from register", {c_cs_o, c_sck_o, c_io3_o, c_io2_o, c_mosi_o},
             {11'd0, 4'b0111, w2[15]});  // engine mosi holds the last word's msb
    @(negedge clk50);

    // controller report
    w0 = $random(seed);
    w1 = $random(seed);
    w2 = $random(seed);
    apb_write(`REG_PAD0, w0);
    apb_write(`REG_PAD1, w1);
    apb_write(`REG_PAD2, w2);
    apb_read(`REG_PAD0, rd);
    check_eq("prdata_o PAD0", rd, w0);
    apb_read(`REG_PAD1, rd);
    check_eq("prdata_o PAD1", rd, w1);
    apb_read(`REG_PAD2, rd);
    check_eq("prdata_o PAD2", rd, w2);
    apb_read(`REG_PAD_STICKS, rd);
    check_eq("prdata_o PAD_STICKS", rd, {2'b00, w0[13:8], 2'b00, w0[5:0]});
    apb_read(`REG_PAD_RIGHT, rd);
    check_eq("prdata_o PAD_RIGHT", rd, {3'b000, w1[4:0], 3'b000, w0[7:6], w0[15:14], w1[7]});
    apb_read(`REG_PAD_TRIG, rd);
    check_eq("prdata_o PAD_TRIG", rd, {3'b000, w1[12:8], 3'b000, w1[6:5], w1[15:13]});

    // unmapped address
    apb_read(12'h3ff, rd);
    check_true(err === 1'b1, "read of unmapped address gave no slave error");
    exp_v = $random(seed);
    apb_write(12'h3ff, exp_v);
    check_true(err === 1'b1, "write to unmapped address gave no slave error");
    apb_read(`REG_PAD0, rd);
    check_eq("prdata_o PAD0 after bad write", rd, w0);
    apb_read(`REG_PAD1, rd);
    check_eq("prdata_o PAD1 after bad write", rd, w1);
    apb_read(`REG_PAD2, rd);
    check_eq("prdata_o PAD2 after bad write", rd, w2);
    apb_read(`REG_DPIN, rd);
    check_eq("prdata_o DPIN after bad write", rd, {10'd0, 4'b1011, d_miso_i, 1'b1});
    apb_read(`REG_MUX, rd);
    check_eq("prdata_o MUX after bad write", rd, 16'h0000);

    repeat (4) @(negedge clk50);
    run_ended = 1'b1;
    $display("Testbench passed");
    $finish;
  end

  ////////////////////
  // watchdog

  initial begin
    #(max_cycles * 10);
    $display("timeout: the run did not finish within %0d clock cycles", max_cycles);
    $display("Testbench failed");
    run_ended = 1'b1;
    $fatal(1);
  end

  // run stopped by a failing concurrent assertion
  final begin
    if (!run_ended)
      $display("Testbench failed");
  end

endmodule

// File: filelist.f
+incdir+hdl
hdl/spi_bridge_pkg.sv
hdl/io_regs.sv
hdl/spi_engine.sv
hdl/pin_mux.sv
hdl/spi_bridge_top.sv
tb/spi_bridge_properties.sv
tb/spi_bridge_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = spi_bridge_tb
FILELIST = filelist.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
